/* hdl/cache_types_pkg.sv */
package cache_types_pkg;

    // byte offset bits below the set index, 16 bytes per line
    localparam int OFFSET_BITS = 4;

    // 32-bit words in one line
    localparam int LINE_WORDS = 4;

    // full byte address from the cpu
    typedef logic [31:0] addr_t;

    // one data word
    typedef logic [31:0] word_t;

    // whole cache line
    // word k sits at bits 32k and up
    typedef logic [LINE_WORDS*32-1:0] line_t;

    // word offset inside a line, address bits 3..2
    typedef logic [1:0] word_sel_t;

endpackage

/* hdl/cache_state_pkg.sv */
package cache_state_pkg;

    // main controller states
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE
    } ctrl_state_t;

    // burst engine states in the memory port
    typedef enum logic [1:0] {
        B_IDLE,
        B_WRITE,
        B_READ_ISSUE,
        B_READ_WAIT
    } burst_state_t;

endpackage

/* hdl/cache_if.sv */
`timescale 1ns/10ps

// held cpu request and its one-cycle answer
interface cpu_req_if;
    import cache_types_pkg::*;

    logic  pending;
    logic  we;
    addr_t addr;
    word_t wdata;
    logic  done;
    word_t rdata;

    modport port (output pending, output we, output addr, output wdata,
                  input done, input rdata);
    modport ctrl (input pending, input we, input addr, input wdata,
                  output done, output rdata);
endinterface

// per-set tag and line storage access
interface array_if #(
    parameter int SET_BITS = 4
);
    import cache_types_pkg::*;

    localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;

    logic [SET_BITS-1:0] index;
    logic [TAG_BITS-1:0] tag_rd;
    logic                valid_rd;
    logic                dirty_rd;
    line_t               line_rd;
    logic                tag_we;
    logic                line_we;
    logic [TAG_BITS-1:0] tag_wr;
    logic                dirty_wr;
    line_t               line_wr;

    modport ctrl (output index, output tag_we, output line_we, output tag_wr,
                  output dirty_wr, output line_wr,
                  input tag_rd, input valid_rd, input dirty_rd, input line_rd);
    modport store (input index, input tag_we, input line_we, input tag_wr,
                   input dirty_wr, input line_wr,
                   output tag_rd, output valid_rd, output dirty_rd, output line_rd);
endinterface

// whole-line transfer between controller and memory port
interface line_bus_if;
    import cache_types_pkg::*;

    logic  req;
    logic  we;
    addr_t addr;
    line_t wline;
    line_t rline;
    logic  done;

    modport ctrl (output req, output we, output addr, output wline,
                  input rline, input done);
    modport port (input req, input we, input addr, input wline,
                  output rline, output done);
endinterface

/* hdl/cpu_port.sv */
`timescale 1ns/10ps

module cpu_port (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_valid_i,
    input  logic                   req_we_i,
    input  cache_types_pkg::addr_t req_addr_i,
    input  cache_types_pkg::word_t req_wdata_i,
    output logic                   resp_valid_o,
    output cache_types_pkg::word_t resp_rdata_o,
    cpu_req_if.port                cpu
);

    // pending and response strobe
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cpu.pending  <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            // answer shows one cycle after done
            resp_valid_o <= cpu.done;
            // done wins, cpu never overlaps requests anyway
            if (cpu.done) begin
                cpu.pending <= 1'b0;
            end else if (req_valid_i) begin
                cpu.pending <= 1'b1;
            end
        end
    end

    // request fields held while pending
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            cpu.we    <= req_we_i;
            cpu.addr  <= req_addr_i;
            cpu.wdata <= req_wdata_i;
        end
    end

    // read data registered together with the strobe
    always_ff @(posedge clk_i) begin
        if (cpu.done) begin
            resp_rdata_o <= cpu.rdata;
        end
    end

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl #(
    parameter int SET_BITS = 4
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    cpu_req_if.ctrl  cpu,
    array_if.ctrl    arr,
    line_bus_if.ctrl line
);
    import cache_types_pkg::*;
    import cache_state_pkg::*;

    localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // fields of the pending address
    logic [TAG_BITS-1:0] req_tag;
    logic [SET_BITS-1:0] req_index;
    word_sel_t           req_sel;

    logic  hit;
    logic  victim_dirty;
    addr_t victim_addr;
    addr_t alloc_addr;
    line_t merged_line;

    assign req_tag   = cpu.addr[31:SET_BITS+OFFSET_BITS];
    assign req_index = cpu.addr[SET_BITS+OFFSET_BITS-1:OFFSET_BITS];
    assign req_sel   = cpu.addr[3:2];

    // storage is always looked up at the request set
    assign arr.index = req_index;

    assign hit          = arr.valid_rd && (arr.tag_rd == req_tag);
    assign victim_dirty = arr.valid_rd && arr.dirty_rd;

    // line base addresses for write-back and refill
    assign victim_addr = {arr.tag_rd, req_index, {OFFSET_BITS{1'b0}}};
    assign alloc_addr  = {req_tag, req_index, {OFFSET_BITS{1'b0}}};

    // stored line with the cpu word dropped in
    always_comb begin
        merged_line = arr.line_rd;
        merged_line[32*req_sel +: 32] = cpu.wdata;
    end

    always_comb begin
        state_d      = state_q;
        cpu.done     = 1'b0;
        cpu.rdata    = arr.line_rd[32*req_sel +: 32];
        arr.tag_we   = 1'b0;
        arr.line_we  = 1'b0;
        arr.tag_wr   = req_tag;
        arr.dirty_wr = 1'b0;
        arr.line_wr  = merged_line;
        line.req     = 1'b0;
        line.we      = 1'b0;
        line.addr    = alloc_addr;
        line.wline   = arr.line_rd;

        case (state_q)
            IDLE: begin
                if (cpu.pending) begin
                    state_d = COMPARE;
                end
            end
            COMPARE: begin
                if (hit) begin
                    cpu.done = 1'b1;
                    // write hit, merge the word and mark the line dirty
                    if (cpu.we) begin
                        arr.line_we  = 1'b1;
                        arr.tag_we   = 1'b1;
                        arr.dirty_wr = 1'b1;
                    end
                    state_d = IDLE;
                end else if (victim_dirty) begin
                    // old line goes out first
                    line.req  = 1'b1;
                    line.we   = 1'b1;
                    line.addr = victim_addr;
                    state_d   = WRITE_BACK;
                end else begin
                    // clean or empty set, refill at once
                    line.req = 1'b1;
                    state_d  = ALLOCATE;
                end
            end
            WRITE_BACK: begin
                // victim written, now fetch the new line
                if (line.done) begin
                    line.req = 1'b1;
                    state_d  = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (line.done) begin
                    // fresh line and clean tag
                    arr.line_we = 1'b1;
                    arr.line_wr = line.rline;
                    arr.tag_we  = 1'b1;
                    // re-compare turns a write miss into a write hit
                    state_d     = COMPARE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* hdl/cache_arrays.sv */
`timescale 1ns/10ps

module cache_arrays #(
    parameter int SET_BITS = 4
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    array_if.store arr
);
    import cache_types_pkg::*;

    localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;
    localparam int NUM_SETS = 1 << SET_BITS;

    // per-set state bits
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    // tags and line words
    logic [TAG_BITS-1:0] tag_q  [NUM_SETS];
    word_t               data_q [NUM_SETS][LINE_WORDS];

    // combinational read of the addressed set
    assign arr.valid_rd = valid_q[arr.index];
    assign arr.dirty_rd = dirty_q[arr.index];
    assign arr.tag_rd   = tag_q[arr.index];

    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            arr.line_rd[32*w +: 32] = data_q[arr.index][w];
        end
    end

    // valid and dirty, cleared for every set on reset
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.tag_we) begin
            valid_q[arr.index] <= 1'b1;
            dirty_q[arr.index] <= arr.dirty_wr;
        end
    end

    // tag store
    always_ff @(posedge clk_i) begin
        if (arr.tag_we) begin
            tag_q[arr.index] <= arr.tag_wr;
        end
    end

    // whole line loaded at once, word by word
    always_ff @(posedge clk_i) begin
        if (arr.line_we) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                data_q[arr.index][w] <= arr.line_wr[32*w +: 32];
            end
        end
    end

endmodule

/* hdl/mem_port.sv */
`timescale 1ns/10ps

module mem_port (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    line_bus_if.port               line,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output cache_types_pkg::addr_t mem_addr_o,
    output cache_types_pkg::word_t mem_wdata_o,
    input  logic                   mem_rvalid_i,
    input  cache_types_pkg::word_t mem_rdata_i
);
    import cache_types_pkg::*;
    import cache_state_pkg::*;

    localparam word_sel_t LAST_BEAT = word_sel_t'(LINE_WORDS - 1);

    burst_state_t state_q;
    burst_state_t state_d;

    // beats issued and read words received
    word_sel_t beat_q;
    word_sel_t rx_q;
    logic      done_q;
    logic      reading;
    logic      accept;

    // own copy of the transfer
    addr_t base_q;
    line_t wline_q;
    line_t rline_q;

    assign reading = (state_q == B_READ_ISSUE) || (state_q == B_READ_WAIT);

    // new transfer taken when idle or with the last write beat
    assign accept = line.req &&
                    ((state_q == B_IDLE) ||
                     ((state_q == B_WRITE) && (beat_q == LAST_BEAT)));

    always_comb begin
        state_d = state_q;
        case (state_q)
            B_IDLE: begin
                if (line.req) begin
                    state_d = line.we ? B_WRITE : B_READ_ISSUE;
                end
            end
            B_WRITE: begin
                if (beat_q == LAST_BEAT) begin
                    // refill may follow the write-back back to back
                    if (line.req) begin
                        state_d = line.we ? B_WRITE : B_READ_ISSUE;
                    end else begin
                        state_d = B_IDLE;
                    end
                end
            end
            B_READ_ISSUE: begin
                if (beat_q == LAST_BEAT) begin
                    state_d = B_READ_WAIT;
                end
            end
            B_READ_WAIT: begin
                if (done_q) begin
                    state_d = B_IDLE;
                end
            end
            default: begin
                state_d = B_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= B_IDLE;
            beat_q  <= '0;
            rx_q    <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= 1'b0;
            if (state_q == B_IDLE) begin
                beat_q <= '0;
                rx_q   <= '0;
            end else begin
                // wraps back to zero after the last beat
                if (state_q != B_READ_WAIT) begin
                    beat_q <= beat_q + 1'b1;
                end
                if (reading && mem_rvalid_i) begin
                    rx_q <= rx_q + 1'b1;
                    // done one cycle after the fourth word
                    if (rx_q == LAST_BEAT) begin
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

    // capture on accept, gather read words by arrival order
    always_ff @(posedge clk_i) begin
        if (accept) begin
            base_q  <= line.addr;
            wline_q <= line.wline;
        end
        if (reading && mem_rvalid_i) begin
            rline_q[32*rx_q +: 32] <= mem_rdata_i;
        end
    end

    assign mem_req_o   = (state_q == B_WRITE) || (state_q == B_READ_ISSUE);
    assign mem_we_o    = (state_q == B_WRITE);
    assign mem_addr_o  = {base_q[31:OFFSET_BITS], beat_q, 2'b00};
    assign mem_wdata_o = wline_q[32*beat_q +: 32];

    // write done rides on the last beat
    assign line.done  = ((state_q == B_WRITE) && (beat_q == LAST_BEAT)) ||
                        ((state_q == B_READ_WAIT) && done_q);
    assign line.rline = rline_q;

endmodule

/* hdl/cache_top.sv */
`timescale 1ns/10ps

module cache_top #(
    parameter int SET_BITS = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // cpu side
    input  logic                   req_valid_i,
    input  logic                   req_we_i,
    input  cache_types_pkg::addr_t req_addr_i,
    input  cache_types_pkg::word_t req_wdata_i,
    output logic                   resp_valid_o,
    output cache_types_pkg::word_t resp_rdata_o,
    // memory side, one word per beat
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output cache_types_pkg::addr_t mem_addr_o,
    output cache_types_pkg::word_t mem_wdata_o,
    input  logic                   mem_rvalid_i,
    input  cache_types_pkg::word_t mem_rdata_i
);

    cpu_req_if                        cpu_bus ();
    array_if #(.SET_BITS(SET_BITS))   arr_bus ();
    line_bus_if                       line_bus ();

    // request capture and response strobe
    cpu_port u_cpu_port (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .cpu          (cpu_bus.port)
    );

    cache_ctrl #(.SET_BITS(SET_BITS)) u_cache_ctrl (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .cpu    (cpu_bus.ctrl),
        .arr    (arr_bus.ctrl),
        .line   (line_bus.ctrl)
    );

    cache_arrays #(.SET_BITS(SET_BITS)) u_cache_arrays (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .arr    (arr_bus.store)
    );

    // line bursts to and from external memory
    mem_port u_mem_port (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .line         (line_bus.port),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

endmodule

/* tests/cache_chk.sv */
`timescale 1ns/10ps

module cache_chk (
    input logic                         clk_i,
    input logic                         rst_ni,
    input cache_state_pkg::ctrl_state_t state_i,
    input logic                         line_req_i,
    input logic                         pending_i,
    input logic                         done_i
);
    import cache_state_pkg::*;

    // transfers start from a tag compare or straight after a write-back
    line_req_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        line_req_i |-> ((state_i == COMPARE) || (state_i == WRITE_BACK)))
        else $error("line request outside COMPARE and WRITE_BACK");

    // answer only to a held request
    done_needs_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_i |-> pending_i)
        else $error("done without a pending request");

    // write-back always hands over to the refill
    write_back_then_allocate: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_i == WRITE_BACK) |=> ((state_i == WRITE_BACK) || (state_i == ALLOCATE)))
        else $error("WRITE_BACK left without going to ALLOCATE");

endmodule

bind cache_ctrl cache_chk u_cache_chk (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .state_i    (state_q),
    .line_req_i (line.req),
    .pending_i  (cpu.pending),
    .done_i     (cpu.done)
);

/* tests/tb_cache.sv */
`timescale 1ns/10ps

module tb_cache;

    localparam int SET_BITS     = 4;
    localparam int TAG_BITS     = 32 - SET_BITS - 4;
    localparam int LINE_WORDS   = 4;
    localparam int NUM_RANDOM   = 400;
    // random phase plus a readback of at most every touched word
    localparam int MAX_REQUESTS = 2 * NUM_RANDOM + 16;
    localparam int WATCHDOG_CYC = MAX_REQUESTS * 40;
    localparam int RESP_LIMIT   = 100;
    // strobe taken at E0, COMPARE after E1, done sampled at E2, seen at E3
    localparam int HIT_EDGES    = 3;

    logic        clk;
    logic        rst_n      = 1'b0;
    logic        req_valid  = 1'b0;
    logic        req_we     = 1'b0;
    logic [31:0] req_addr   = '0;
    logic [31:0] req_wdata  = '0;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_rvalid = 1'b0;
    logic [31:0] mem_rdata  = '0;

    integer seed = 32'h93edb7ff;
    int     checks = 0;
    int     errors = 0;

    // memory model, only written words are stored
    logic [31:0] mem_q [logic [9:0]];
    logic [31:0] rd_pending [$];
    int          delay_tab [64];
    logic [5:0]  delay_ptr = '0;
    int          rd_delay  = 0;

    // every memory beat in order of issue
    logic        beat_we   [$];
    logic [31:0] beat_addr [$];
    logic [31:0] beat_data [$];

    // flat word model and shadow tag state
    logic [31:0]         flat_q [logic [9:0]];
    bit                  touched [1024];
    logic [TAG_BITS-1:0] sh_tag [1 << SET_BITS];
    logic [15:0]         sh_valid = '0;
    logic [15:0]         sh_dirty = '0;

    cache_top #(.SET_BITS(SET_BITS)) dut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .req_valid_i  (req_valid),
        .req_we_i     (req_we),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .resp_valid_o (resp_valid),
        .resp_rdata_o (resp_rdata),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // power-up content, mixes all address bits
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a96e1;
    endfunction

    function automatic logic [31:0] stored_word(input logic [31:0] addr);
        return mem_q.exists(addr[11:2]) ? mem_q[addr[11:2]] : fill_word(addr);
    endfunction

    function automatic logic [31:0] flat_value(input logic [31:0] addr);
        return flat_q.exists(addr[11:2]) ? flat_q[addr[11:2]] : fill_word(addr);
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("FAIL %0t: %s", $time, msg);
        end
    endtask

    // memory: stores write beats, answers reads in order after 1 to 4 cycles
    always @(posedge clk) begin
        mem_rvalid <= 1'b0;
        if (mem_req && mem_we) begin
            mem_q[mem_addr[11:2]] = mem_wdata;
        end
        if (mem_req && !mem_we) begin
            rd_pending.push_back(mem_addr);
        end
        if (rd_pending.size() != 0) begin
            if (rd_delay == 0) begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= stored_word(rd_pending[0]);
                void'(rd_pending.pop_front());
                rd_delay  = delay_tab[delay_ptr];
                delay_ptr = delay_ptr + 1'b1;
            end else begin
                rd_delay = rd_delay - 1;
            end
        end
    end

    // beat log
    always @(posedge clk) begin
        if (mem_req) begin
            beat_we.push_back(mem_we);
            beat_addr.push_back(mem_addr);
            beat_data.push_back(mem_wdata);
        end
    end

    // one cpu request, checked against the shadow and flat models
    task automatic access(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
        logic [SET_BITS-1:0] set;
        logic [TAG_BITS-1:0] tag;
        logic                hit;
        int                  n_wb;
        int                  n_beats;
        int                  first;
        int                  edges;
        bit                  got;
        logic [1:0]          off;
        logic                exp_we;
        logic [31:0]         exp_addr;
        logic [31:0]         exp_rdata;
        set       = addr[SET_BITS+3:4];
        tag       = addr[31:SET_BITS+4];
        hit       = sh_valid[set] && (sh_tag[set] == tag);
        // dirty victim goes out before the refill
        n_wb      = (!hit && sh_valid[set] && sh_dirty[set]) ? LINE_WORDS : 0;
        n_beats   = hit ? 0 : n_wb + LINE_WORDS;
        exp_rdata = flat_value(addr);
        first     = beat_addr.size();

        @(posedge clk);
        req_valid <= 1'b1;
        req_we    <= we;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(posedge clk);
        req_valid <= 1'b0;
        edges = 0;
        got   = 1'b0;
        while (!got && edges < RESP_LIMIT) begin
            @(posedge clk);
            edges++;
            got = resp_valid;
        end

        assert (got) else begin
            errors++;
            $display("no response within %0d cycles to the %s at address %h",
                     RESP_LIMIT, we ? "write" : "read", addr);
        end

        if (got) begin
            if (!we) begin
                check(resp_rdata == exp_rdata,
                      $sformatf("read %h returned %h, expected %h", addr, resp_rdata, exp_rdata));
            end
            if (hit) begin
                check(edges == HIT_EDGES,
                      $sformatf("hit at %h answered after %0d edges, expected %0d",
                                addr, edges, HIT_EDGES));
            end
            check(beat_addr.size() - first == n_beats,
                  $sformatf("%0d memory beats for %h, expected %0d",
                            beat_addr.size() - first, addr, n_beats));
            if (beat_addr.size() - first == n_beats) begin
                for (int k = 0; k < n_beats; k++) begin
                    if (k < n_wb) begin
                        off      = 2'(k);
                        exp_we   = 1'b1;
                        exp_addr = {sh_tag[set], set, off, 2'b00};
                    end else begin
                        off      = 2'(k - n_wb);
                        exp_we   = 1'b0;
                        exp_addr = {tag, set, off, 2'b00};
                    end
                    check((beat_we[first+k] == exp_we) && (beat_addr[first+k] == exp_addr),
                          $sformatf("beat %0d at %h we %b, expected %h we %b", k,
                                    beat_addr[first+k], beat_we[first+k], exp_addr, exp_we));
                    if (exp_we) begin
                        check(beat_data[first+k] == flat_value(exp_addr),
                              $sformatf("write-back of %h carried %h, expected %h", exp_addr,
                                        beat_data[first+k], flat_value(exp_addr)));
                    end
                end
            end
        end

        // models follow the request
        if (!hit) begin
            sh_valid[set] = 1'b1;
            sh_tag[set]   = tag;
            sh_dirty[set] = 1'b0;
        end
        if (we) begin
            sh_dirty[set]        = 1'b1;
            flat_q[addr[11:2]]   = wdata;
        end
        touched[addr[11:2]] = 1'b1;
    endtask

    initial begin : main
        int          c0;
        int          e0;
        int          n_read;
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] last_addr;
        logic [31:0] wdata;
        logic        we;
        last_addr = '0;
        n_read    = 0;
        for (int k = 0; k < 64; k++) begin
            delay_tab[6'(k)] = $unsigned($random(seed)) % 4;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // idle outputs right after reset
        c0 = checks;
        e0 = errors;
        repeat (4) begin
            @(posedge clk);
            check(!resp_valid && !mem_req,
                  $sformatf("resp_valid %b mem_req %b before any request", resp_valid, mem_req));
        end
        $display("test reset_idle: %0d checks, %0d errors", checks - c0, errors - e0);

        // random reads and writes in a 4 KB window
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            // a quarter stay in the last line so hits occur
            if (r[30:29] == 2'b00) begin
                addr = {last_addr[31:4], r[3:2], 2'b00};
            end else begin
                addr = {20'd0, r[11:2], 2'b00};
            end
            we    = r[31];
            wdata = $random(seed);
            access(we, addr, wdata);
            last_addr = addr;
        end
        $display("test random_traffic: %0d checks, %0d errors", checks - c0, errors - e0);

        // read every touched word once more
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 1024; i++) begin
            if (touched[10'(i)]) begin
                access(1'b0, {20'd0, 10'(i), 2'b00}, '0);
                n_read++;
            end
        end
        $display("test final_readback: %0d reads, %0d checks, %0d errors",
                 n_read, checks - c0, errors - e0);

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYC);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* build.f */
hdl/cache_types_pkg.sv
hdl/cache_state_pkg.sv
hdl/cache_if.sv
hdl/cpu_port.sv
hdl/cache_ctrl.sv
hdl/cache_arrays.sv
hdl/mem_port.sv
hdl/cache_top.sv
tests/cache_chk.sv
tests/tb_cache.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cache -f build.f

./obj_dir/Vtb_cache | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "run passed"
    exit 0
else
    echo "run failed, see sim.log"
    exit 1
fi
